/* vlog.f */
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/alu.sv
hdl/regfile.sv
hdl/execute_stage.sv
hdl/decode_stage.sv
hdl/apb_port.sv
hdl/rv_core_top.sv
tests/core_sva.sv
tests/tb_core.sv

/* Makefile */
# Verilator build, run and lint for the RV64I pipeline slice

SIM := obj_dir/Vtb_core

.PHONY: all lint clean

all: $(SIM)
	$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

$(SIM): vlog.f $(wildcard hdl/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_core -f vlog.f

lint:
	verilator --lint-only -Wall --timing --top-module tb_core -f vlog.f

clean:
	rm -rf obj_dir sim.log

/* tests/tb_core.sv */
/*
 * testbench for the RV64I pipeline slice
 * drives APB transfers for register setup, illegal accesses, x0 and
 * unsupported opcodes, then random and chained programs; the bound
 * checker compares every completion
 */

`timescale 1ns/1ps

module tb_core
    import rv_isa_pkg::*;
    import core_pkg::*;
();

    localparam int unsigned HART_ID = 3;
    localparam int N_RAND = 150;
    // every random instruction may be followed by one read
    localparam int MAX_XFERS = 31 + 3 * 32 + 12 + 4 * N_RAND;
    localparam int WATCHDOG_CYCLES = MAX_XFERS * 40;

    logic        c_clk;
    logic        c_rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] rng;
    reg_idx_t    last_rd;
    reg_idx_t    prev_rd;
    int          errs;

    rv_core_top #(
        .HART_ID (HART_ID)
    ) rv_core_top_i (
        .c_clk   (c_clk),
        .c_rst_n (c_rst_n),
        .apb_i   (apb_req),
        .apb_o   (apb_rsp)
    );

    initial begin
        c_clk = 1'b0;
        forever begin
            #4 c_clk = ~c_clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [APB_AW-1:0] reg_addr(input reg_idx_t n);
        return ADDR_REG_BASE + {4'd0, n, 3'd0};
    endfunction

    function automatic logic [31:0] addi_instr(input reg_idx_t rd, input reg_idx_t rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, F3_ADD, rd, OPC_OP_IMM};
    endfunction

    // mostly legal encodings, some outside the kept set
    function automatic instr_t rand_instr(input reg_idx_t rd, input reg_idx_t rs1,
                                          input reg_idx_t rs2);
        logic [31:0] r;
        instr_t      i;
        r     = rand32();
        i     = instr_t'(rand32());
        i.rd  = rd;
        i.rs1 = rs1;
        case (r[3:0])
            4'd0, 4'd1: begin
                i.opcode = OPC_LUI;
            end
            4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7: begin
                i.opcode = OPC_OP_IMM;
                if (i.funct3 == F3_SLL) begin
                    i.funct7 = {6'd0, r[5]};
                end else if (i.funct3 == F3_SR) begin
                    i.funct7 = {1'b0, r[4], 4'd0, r[5]};
                end
            end
            4'd14: begin
                i.opcode = 7'b0001011;
            end
            default: begin
                i.opcode = OPC_OP;
                i.rs2    = rs2;
                i.funct7 = (r[4] && (i.funct3 == F3_ADD || i.funct3 == F3_SR)) ? F7_ALT : F7_BASE;
                // M extension encoding, not kept
                if (r[3:0] == 4'd15) begin
                    i.funct7 = 7'h01;
                end
            end
        endcase
        return i;
    endfunction

    // entered and left just after a falling edge, so transfers can abut
    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [31:0] data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge c_clk);
        apb_req.penable = 1'b1;
        while (!apb_rsp.pready) begin
            @(negedge c_clk);
        end
        @(negedge c_clk);
    endtask

    task automatic bus_idle();
        apb_req = '0;
        @(negedge c_clk);
    endtask

    task automatic read_all();
        for (int n = 0; n < 32; n++) begin
            apb_xfer(1'b0, reg_addr(reg_idx_t'(n)), '0);
        end
    endtask

    // chain mode feeds the two previous results into rs1 and rs2
    task automatic run_program(input int n, input logic chain);
        logic [31:0] r;
        instr_t      i;
        reg_idx_t    rd;
        for (int k = 0; k < n; k++) begin
            r  = rand32();
            rd = (chain && r[4:0] == 5'd0) ? 5'd1 : r[4:0];
            if (chain) begin
                i = rand_instr(rd, last_rd, prev_rd);
            end else begin
                i = rand_instr(rd, r[9:5], r[14:10]);
            end
            apb_xfer(1'b1, ADDR_INSTR, i);
            prev_rd = last_rd;
            last_rd = rd;
            // read right behind the write, held by back-pressure
            if (r[16:15] == 2'b00) begin
                apb_xfer(1'b0, reg_addr(rd), '0);
            end
        end
    endtask

    initial begin
        rng     = 32'd28;
        last_rd = 5'd1;
        prev_rd = 5'd2;
        c_rst_n = 1'b0;
        apb_req = '0;
        repeat (4) @(negedge c_clk);
        c_rst_n = 1'b1;
        // registers have no reset, give each a value first
        for (int n = 1; n < 32; n++) begin
            apb_xfer(1'b1, ADDR_INSTR, addi_instr(reg_idx_t'(n), 5'd0, 12'(rand32())));
        end
        read_all();
        bus_idle();
        apb_xfer(1'b0, ADDR_HART, '0);
        apb_xfer(1'b1, ADDR_HART, 32'h0000_1234);
        apb_xfer(1'b0, ADDR_INSTR, '0);
        apb_xfer(1'b0, 12'h008, '0);
        apb_xfer(1'b0, 12'h104, '0);
        apb_xfer(1'b1, reg_addr(5'd4), 32'hffff_ffff);
        apb_xfer(1'b0, 12'h200, '0);
        // x0 as a target stays zero
        apb_xfer(1'b1, ADDR_INSTR, addi_instr(5'd0, 5'd5, 12'h7ff));
        apb_xfer(1'b1, ADDR_INSTR, {20'hfffff, 5'd0, OPC_LUI});
        apb_xfer(1'b0, reg_addr(5'd0), '0);
        apb_xfer(1'b1, ADDR_INSTR, {20'h12345, 5'd3, 7'b0001011});
        apb_xfer(1'b0, reg_addr(5'd3), '0);
        read_all();
        run_program(N_RAND, 1'b0);
        run_program(N_RAND, 1'b1);
        read_all();
        bus_idle();
        repeat (2) @(negedge c_clk);
        errs = rv_core_top_i.core_sva_i.data_errs + rv_core_top_i.core_sva_i.resp_errs
             + rv_core_top_i.core_sva_i.proto_errs;
        $display("errors: data %0d, response %0d, protocol %0d",
                 rv_core_top_i.core_sva_i.data_errs, rv_core_top_i.core_sva_i.resp_errs,
                 rv_core_top_i.core_sva_i.proto_errs);
        if (errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge c_clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* tests/core_sva.sv */
/*
 * APB and architectural checker for the core
 * steps a shadow register file by the RV64I rules on every completed
 * instruction write and checks each APB completion against it
 */

`timescale 1ns/1ps

module core_sva
    import rv_isa_pkg::*;
    import core_pkg::*;
#(
    parameter int unsigned HART_ID = 0
) (
    input logic     c_clk,
    input logic     c_rst_n,
    input apb_req_t apb_req_i,
    input apb_rsp_t apb_rsp_i,
    input logic     issue_valid_i,
    input logic     id_busy_i,
    input logic     ex_busy_i
);

    int data_errs = 0;
    int resp_errs = 0;
    int proto_errs = 0;

    logic [XLEN-1:0] shadow [32];
    logic [XLEN:0]   step;
    logic            access;
    logic            done;
    logic            is_reg;
    logic            exp_err;
    logic            in_flight;
    reg_idx_t        idx;
    instr_t          ins;

    // reference result of one instruction, msb set when it writes rd
    function automatic logic [XLEN:0] iss_step(input instr_t i, input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] op_b;
        logic [XLEN-1:0] sra;
        logic [XLEN-1:0] y;
        logic            alt;
        logic            ok;
        imm = {{(XLEN-12){i.funct7[6]}}, i.funct7, i.rs2};
        if (i.opcode == OPC_LUI) begin
            return {1'b1, {(XLEN-32){i.funct7[6]}}, i[31:12], 12'h000};
        end
        if (i.opcode == OPC_OP_IMM) begin
            op_b = imm;
            alt  = (i.funct3 == F3_SR) && i.funct7[5];
            // six bit shift amount, srai sets only bit 30 above it
            ok   = (i.funct3 == F3_SLL) ? (i.funct7[6:1] == 6'd0)
                 : (i.funct3 == F3_SR) ? ({i.funct7[6], i.funct7[4:1]} == 5'd0) : 1'b1;
        end else if (i.opcode == OPC_OP) begin
            op_b = b;
            alt  = i.funct7[5];
            ok   = (i.funct7 == F7_BASE)
                 || ((i.funct7 == F7_ALT) && (i.funct3 == F3_ADD || i.funct3 == F3_SR));
        end else begin
            return '0;
        end
        sra = $signed(a) >>> op_b[5:0];
        case (i.funct3)
            F3_ADD:  y = alt ? a - op_b : a + op_b;
            F3_SLL:  y = a << op_b[5:0];
            F3_SLT:  y = XLEN'($signed(a) < $signed(op_b));
            F3_SLTU: y = XLEN'(a < op_b);
            F3_XOR:  y = a ^ op_b;
            F3_SR:   y = alt ? sra : a >> op_b[5:0];
            F3_OR:   y = a | op_b;
            default: y = a & op_b;
        endcase
        return {ok, y};
    endfunction

    assign access    = apb_req_i.psel && apb_req_i.penable;
    assign done      = access && apb_rsp_i.pready;
    assign is_reg    = (apb_req_i.paddr[11:8] == 4'h1) && (apb_req_i.paddr[2:0] == 3'd0);
    assign idx       = apb_req_i.paddr[7:3];
    assign in_flight = issue_valid_i || id_busy_i || ex_busy_i;
    // legal are instruction writes, hart reads and register reads
    assign exp_err   = !((apb_req_i.pwrite && apb_req_i.paddr == ADDR_INSTR)
                      || (!apb_req_i.pwrite && (apb_req_i.paddr == ADDR_HART || is_reg)));
    assign ins       = instr_t'(apb_req_i.pwdata);
    assign step      = iss_step(ins, shadow[ins.rs1], shadow[ins.rs2]);

    always_ff @(posedge c_clk) begin
        if (!c_rst_n) begin
            for (int n = 0; n < 32; n++) begin
                shadow[n] <= '0;
            end
        end else if (done && apb_req_i.pwrite && !exp_err && step[XLEN] && ins.rd != 5'd0) begin
            shadow[ins.rd] <= step[XLEN-1:0];
        end
    end

    a_reg_read: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        done && !apb_req_i.pwrite && is_reg |-> apb_rsp_i.prdata == shadow[idx])
        else begin
            data_errs++;
            $error("Fail reg_read x%0d: expected %h actual %h", $sampled(idx),
                   $sampled(shadow[idx]), $sampled(apb_rsp_i.prdata));
        end

    a_x0_zero: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        done && !apb_req_i.pwrite && apb_req_i.paddr == ADDR_REG_BASE
        |-> apb_rsp_i.prdata == '0)
        else begin
            data_errs++;
            $error("Fail x0_read: expected 0 actual %h", $sampled(apb_rsp_i.prdata));
        end

    a_hart_id: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        done && !apb_req_i.pwrite && apb_req_i.paddr == ADDR_HART
        |-> apb_rsp_i.prdata == XLEN'(HART_ID))
        else begin
            data_errs++;
            $error("Fail hart_read: expected %h actual %h", XLEN'(HART_ID),
                   $sampled(apb_rsp_i.prdata));
        end

    a_slverr: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        done |-> apb_rsp_i.pslverr == exp_err)
        else begin
            resp_errs++;
            $error("Fail slverr at %h: expected %b actual %b", $sampled(apb_req_i.paddr),
                   $sampled(exp_err), $sampled(apb_rsp_i.pslverr));
        end

    a_ready_idle: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        apb_rsp_i.pready |-> access)
        else begin
            proto_errs++;
            $error("pready is high outside an access phase");
        end

    // writes, hart reads and illegal accesses finish in one access cycle
    a_fast_done: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        access && (apb_req_i.pwrite || apb_req_i.paddr == ADDR_HART || exp_err)
        |-> apb_rsp_i.pready)
        else begin
            proto_errs++;
            $error("transfer at %h did not complete in its first access cycle",
                   $sampled(apb_req_i.paddr));
        end

    a_read_hold: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        access && !apb_req_i.pwrite && is_reg && in_flight |-> !apb_rsp_i.pready)
        else begin
            proto_errs++;
            $error("register read completed while an instruction was in flight");
        end

    a_reset_idle: assert property (@(posedge c_clk)
        c_rst_n && !$past(c_rst_n) |-> !apb_rsp_i.pready && !apb_rsp_i.pslverr)
        else begin
            proto_errs++;
            $error("pready or pslverr high right after reset");
        end

endmodule

bind rv_core_top core_sva #(
    .HART_ID       (HART_ID)
) core_sva_i (
    .c_clk         (c_clk),
    .c_rst_n       (c_rst_n),
    .apb_req_i     (apb_i),
    .apb_rsp_i     (apb_o),
    .issue_valid_i (issue.valid),
    .id_busy_i     (id_busy),
    .ex_busy_i     (ex_busy)
);

/* hdl/rv_core_top.sv */
/*
 * RV64I integer pipeline slice
 * instructions are issued by APB writes, pass through decode and
 * execute and retire into the register file; APB reads return
 * register contents or the hart id
 */

`timescale 1ns/1ps

module rv_core_top
    import rv_isa_pkg::*;
    import core_pkg::*;
#(
    parameter int unsigned HART_ID = 5
) (
    input  logic     c_clk,
    input  logic     c_rst_n,
    input  apb_req_t apb_i,
    output apb_rsp_t apb_o
);

    issue_t          issue;
    id_ex_t          id_ex;
    ex_wb_t          ex_wb;
    reg_idx_t        dbg_idx;
    logic [XLEN-1:0] dbg_data;
    logic            id_busy;
    logic            ex_busy;

    apb_port #(
        .HART_ID    (HART_ID)
    ) apb_port_i (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .apb_i      (apb_i),
        .apb_o      (apb_o),
        .issue_o    (issue),
        .dbg_idx_o  (dbg_idx),
        .dbg_data_i (dbg_data),
        .id_busy_i  (id_busy),
        .ex_busy_i  (ex_busy)
    );

    decode_stage decode_stage_i (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .issue_i    (issue),
        .wb_i       (ex_wb),
        .dbg_idx_i  (dbg_idx),
        .dbg_data_o (dbg_data),
        .id_ex_o    (id_ex),
        .busy_o     (id_busy)
    );

    execute_stage execute_stage_i (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .id_ex_i    (id_ex),
        .ex_wb_o    (ex_wb),
        .busy_o     (ex_busy)
    );

endmodule

/* hdl/apb_port.sv */
/*
 * APB slave port of the core
 * a write to the instruction register issues one instruction, reads
 * return the hart id or a register; register reads wait until the
 * pipeline is empty, illegal accesses complete with pslverr
 */

`timescale 1ns/1ps

module apb_port
    import rv_isa_pkg::*;
    import core_pkg::*;
#(
    parameter int unsigned HART_ID = 0
) (
    input  logic            c_clk,
    input  logic            c_rst_n,
    input  apb_req_t        apb_i,
    output apb_rsp_t        apb_o,
    output issue_t          issue_o,
    output reg_idx_t        dbg_idx_o,
    input  logic [XLEN-1:0] dbg_data_i,
    input  logic            id_busy_i,
    input  logic            ex_busy_i
);

    logic            setup;
    logic            access;
    logic            is_instr;
    logic            is_hart;
    logic            is_reg;
    logic            bad;
    logic            done_now;
    logic            in_flight;
    logic            wr_done;
    logic [XLEN-1:0] rdata_d;
    logic            pready_q;
    logic            pslverr_q;
    logic [XLEN-1:0] prdata_q;
    issue_t          issue_q;

    assign setup  = apb_i.psel && !apb_i.penable;
    assign access = apb_i.psel && apb_i.penable;

    // address decode
    assign is_instr = apb_i.paddr == ADDR_INSTR;
    assign is_hart  = apb_i.paddr == ADDR_HART;
    assign is_reg   = (apb_i.paddr[11:8] == ADDR_REG_BASE[11:8]) && (apb_i.paddr[2:0] == 3'b0);

    // unmapped, write to read-only space, or read of the instruction register
    assign bad = !(is_instr || is_hart || is_reg)
               || (apb_i.pwrite && !is_instr)
               || (!apb_i.pwrite && is_instr);

    // something still on its way to the register file
    assign in_flight = issue_q.valid || id_busy_i || ex_busy_i;

    assign done_now = bad || apb_i.pwrite || is_hart || !in_flight;

    assign dbg_idx_o = apb_i.paddr[7:3];
    assign rdata_d   = is_hart ? XLEN'(HART_ID) : (is_reg ? dbg_data_i : '0);

    // instruction write completes on this edge
    assign wr_done = access && pready_q && apb_i.pwrite && is_instr;

    always_ff @(posedge c_clk) begin
        if (!c_rst_n) begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else if (setup) begin
            pready_q  <= done_now;
            pslverr_q <= bad;
        end else if (access && !pready_q) begin
            // held register read
            pready_q  <= !in_flight;
            pslverr_q <= 1'b0;
        end else begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end
    end

    // read data follows the source until the transfer is ready
    always_ff @(posedge c_clk) begin
        if (!pready_q) begin
            prdata_q <= rdata_d;
        end
    end

    always_ff @(posedge c_clk) begin
        if (!c_rst_n) begin
            issue_q.valid <= 1'b0;
        end else begin
            issue_q.valid <= wr_done;
            issue_q.instr <= apb_i.pwdata;
        end
    end

    assign issue_o = issue_q;

    assign apb_o.pready  = pready_q;
    assign apb_o.pslverr = pslverr_q;
    assign apb_o.prdata  = prdata_q;

endmodule

/* hdl/decode_stage.sv */
/*
 * decode stage
 * turns the issued instruction into an ALU operation, builds the
 * I or U immediate, reads both operands and registers the payload
 * for execute; also owns the register file and its writeback
 */

`timescale 1ns/1ps

module decode_stage
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic            c_clk,
    input  logic            c_rst_n,
    input  issue_t          issue_i,
    input  ex_wb_t          wb_i,
    input  reg_idx_t        dbg_idx_i,
    output logic [XLEN-1:0] dbg_data_o,
    output id_ex_t          id_ex_o,
    output logic            busy_o
);

    instr_t          ir;
    logic [XLEN-1:0] r1;
    logic [XLEN-1:0] r2;
    id_ex_t          id_ex_d;
    id_ex_t          id_ex_q;

    assign ir = issue_i.instr;

    // alt selects sub for add and sra for shift right
    function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    regfile regfile_i (
        .c_clk     (c_clk),
        .rs1_i     (ir.rs1),
        .rs2_i     (ir.rs2),
        .dbg_idx_i (dbg_idx_i),
        .rd_i      (wb_i.rd),
        .wr_i      (wb_i.valid && wb_i.wr),
        .d_i       (wb_i.result),
        .r1_o      (r1),
        .r2_o      (r2),
        .dbg_o     (dbg_data_o)
    );

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.valid   = issue_i.valid;
        id_ex_d.rd      = ir.rd;
        id_ex_d.rs1     = ir.rs1;
        id_ex_d.rs2     = ir.rs2;
        id_ex_d.op_a    = r1;
        id_ex_d.op_b    = r2;
        id_ex_d.alu_op  = ALU_ADD;
        // I-type by default
        id_ex_d.imm     = {{(XLEN-12){ir.funct7[6]}}, ir.funct7, ir.rs2};
        case (ir.opcode)
            OPC_OP_IMM: begin
                id_ex_d.use_imm = 1'b1;
                id_ex_d.alu_op  = f3_op(ir.funct3, (ir.funct3 == F3_SR) && ir.funct7[5]);
                // shamt is six bits, the rest of the upper field must be clear
                if (ir.funct3 == F3_SLL) begin
                    id_ex_d.wr = ir.funct7[6:1] == 6'b0;
                end else if (ir.funct3 == F3_SR) begin
                    id_ex_d.wr = {ir.funct7[6], ir.funct7[4:1]} == 5'b0;
                end else begin
                    id_ex_d.wr = 1'b1;
                end
            end
            OPC_OP: begin
                id_ex_d.alu_op = f3_op(ir.funct3, ir.funct7[5]);
                id_ex_d.wr     = (ir.funct7 == F7_BASE)
                              || ((ir.funct7 == F7_ALT)
                                  && (ir.funct3 == F3_ADD || ir.funct3 == F3_SR));
            end
            OPC_LUI: begin
                id_ex_d.use_imm = 1'b1;
                id_ex_d.alu_op  = ALU_PASS_B;
                id_ex_d.imm     = {{(XLEN-32){ir.funct7[6]}}, ir[31:12], 12'b0};
                id_ex_d.wr      = 1'b1;
            end
            default: begin
                // unsupported, retires without a write
                id_ex_d.wr = 1'b0;
            end
        endcase
    end

    always_ff @(posedge c_clk) begin
        if (!c_rst_n) begin
            id_ex_q.valid <= 1'b0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;
    assign busy_o  = id_ex_q.valid;

endmodule

/* hdl/execute_stage.sv */
/*
 * execute stage
 * picks the freshest operand values from the execute/writeback and
 * writeback-forward registers, selects the immediate for b, runs the
 * ALU and registers the result for writeback
 */

`timescale 1ns/1ps

module execute_stage
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic   c_clk,
    input  logic   c_rst_n,
    input  id_ex_t id_ex_i,
    output ex_wb_t ex_wb_o,
    output logic   busy_o
);

    ex_wb_t          ex_wb_d;
    ex_wb_t          ex_wb_q;
    ex_wb_t          wbf_q;
    logic [XLEN-1:0] a_fwd;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] b_sel;
    logic [XLEN-1:0] y;

    // newest value of one source register
    function automatic logic [XLEN-1:0] fwd(input reg_idx_t rs, input logic [XLEN-1:0] rf_val,
                                            input ex_wb_t ex, input ex_wb_t wbf);
        if (rs == '0) begin
            return rf_val;
        end else if (ex.valid && ex.wr && ex.rd == rs) begin
            return ex.result;
        end else if (wbf.valid && wbf.wr && wbf.rd == rs) begin
            return wbf.result;
        end
        return rf_val;
    endfunction

    assign a_fwd   = fwd(id_ex_i.rs1, id_ex_i.op_a, ex_wb_q, wbf_q);
    assign rs2_fwd = fwd(id_ex_i.rs2, id_ex_i.op_b, ex_wb_q, wbf_q);
    assign b_sel   = id_ex_i.use_imm ? id_ex_i.imm : rs2_fwd;

    alu alu_i (
        .a_i  (a_fwd),
        .b_i  (b_sel),
        .op_i (id_ex_i.alu_op),
        .y_o  (y)
    );

    always_comb begin
        ex_wb_d.valid  = id_ex_i.valid;
        ex_wb_d.wr     = id_ex_i.wr;
        ex_wb_d.rd     = id_ex_i.rd;
        ex_wb_d.result = y;
    end

    // wbf keeps the result written on the last edge for one more cycle
    always_ff @(posedge c_clk) begin
        if (!c_rst_n) begin
            ex_wb_q.valid <= 1'b0;
            wbf_q.valid   <= 1'b0;
        end else begin
            ex_wb_q <= ex_wb_d;
            wbf_q   <= ex_wb_q;
        end
    end

    assign ex_wb_o = ex_wb_q;
    assign busy_o  = ex_wb_q.valid;

endmodule

/* hdl/regfile.sv */
/*
 * integer register file
 * 32 x XLEN, two operand read ports, one debug read port and one
 * write port; x0 reads zero and is never written
 */

`timescale 1ns/1ps

module regfile
    import rv_isa_pkg::*;
(
    input  logic            c_clk,
    input  reg_idx_t        rs1_i,
    input  reg_idx_t        rs2_i,
    input  reg_idx_t        dbg_idx_i,
    input  reg_idx_t        rd_i,
    input  logic            wr_i,
    input  logic [XLEN-1:0] d_i,
    output logic [XLEN-1:0] r1_o,
    output logic [XLEN-1:0] r2_o,
    output logic [XLEN-1:0] dbg_o
);

    logic [XLEN-1:0] mem [32];

    always_ff @(posedge c_clk) begin
        if (wr_i && rd_i != '0) begin
            mem[rd_i] <= d_i;
        end
    end

    // entry 0 is never written, so force the zero on read
    assign r1_o  = (rs1_i == '0) ? '0 : mem[rs1_i];
    assign r2_o  = (rs2_i == '0) ? '0 : mem[rs2_i];
    assign dbg_o = (dbg_idx_i == '0) ? '0 : mem[dbg_idx_i];

endmodule

/* hdl/alu.sv */
/*
 * integer ALU
 * add, sub, shifts, compares and logic ops on XLEN operands,
 * plus a pass of b for LUI
 */

`timescale 1ns/1ps

module alu
    import rv_isa_pkg::*;
(
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  alu_op_e         op_i,
    output logic [XLEN-1:0] y_o
);

    logic [5:0] shamt;
    logic       lt_s;
    logic       lt_u;

    // RV64 shifts take the low six bits
    assign shamt = b_i[5:0];

    assign lt_s = $signed(a_i) < $signed(b_i);
    assign lt_u = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:    y_o = a_i + b_i;
            ALU_SUB:    y_o = a_i - b_i;
            ALU_SLL:    y_o = a_i << shamt;
            ALU_SLT:    y_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   y_o = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:    y_o = a_i ^ b_i;
            ALU_SRL:    y_o = a_i >> shamt;
            ALU_SRA:    y_o = $signed(a_i) >>> shamt;
            ALU_OR:     y_o = a_i | b_i;
            ALU_AND:    y_o = a_i & b_i;
            ALU_PASS_B: y_o = b_i;
            default:    y_o = '0;
        endcase
    end

endmodule

/* hdl/core_pkg.sv */
/*
 * core pipeline and bus types
 * APB request/response structs, the APB address map and the payloads
 * carried between issue, decode, execute and writeback
 */

package core_pkg;
    import rv_isa_pkg::*;

    localparam int APB_AW = 12;

    // address map
    localparam logic [APB_AW-1:0] ADDR_INSTR    = 12'h000;
    localparam logic [APB_AW-1:0] ADDR_HART     = 12'h004;
    localparam logic [APB_AW-1:0] ADDR_REG_BASE = 12'h100;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [31:0]       pwdata;
    } apb_req_t;

    typedef struct packed {
        logic            pready;
        logic            pslverr;
        logic [XLEN-1:0] prdata;
    } apb_rsp_t;

    typedef struct packed {
        logic   valid;
        instr_t instr;
    } issue_t;

    typedef struct packed {
        logic            valid;
        reg_idx_t        rd;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] op_b;
        logic [XLEN-1:0] imm;
        alu_op_e         alu_op;
        logic            use_imm;
        logic            wr;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic            wr;
        reg_idx_t        rd;
        logic [XLEN-1:0] result;
    } ex_wb_t;

endpackage

/* hdl/rv_isa_pkg.sv */
/*
 * RV64I ISA definitions
 * opcodes, funct fields, instruction layout and the ALU operation set
 * used by the decode and execute stages
 */

package rv_isa_pkg;

    // data path width
    localparam int XLEN = 64;

    typedef logic [4:0] reg_idx_t;

    // major opcodes kept in this core
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 values shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct7 for base ops and for sub/sra
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // R-type field layout, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

endpackage
